//--- hdl/mio_config.svh
// link sizing macros: packet width, io width, fifo depth, sync stage count

`ifndef MIO_CONFIG_SVH
`define MIO_CONFIG_SVH

//##########################################################################
// core side
//##########################################################################

// wide core packet, sent msb first
`define MIO_PW 104

//##########################################################################
// pin side
//##########################################################################

// pin data width, one link word is twice this
`define MIO_IOW 16

//##########################################################################
// buffering and retiming
//##########################################################################

// entries in the transmit fifo, keep a power of two >= 2
`define MIO_FIFO_DEPTH 4

// flops between the async pin wait and core logic (>= 2)
`define MIO_SYNC_STAGES 2

`endif

//--- hdl/mio_pkg.sv
// link types: core packet, io word, word count

`include "mio_config.svh"

package mio_pkg;

   // one core packet as written by the core
   typedef logic [`MIO_PW-1:0] packet_t;

   // one link word, two pin widths wide
   typedef logic [2*`MIO_IOW-1:0] io_word_t;

   // words per packet minus one
   // wide enough for every word of a full packet
   typedef logic [$clog2(2*`MIO_PW/`MIO_IOW)-1:0] count_t;

endpackage

//--- hdl/mtx_fifo.sv
// mtx_fifo: synchronous circular fifo for core packets ahead of the engine

`timescale 1ns/100ps

`include "mio_config.svh"

module mtx_fifo (
   input  logic             clk,        // core clock
   input  logic             nreset,     // async, active low
   // write side (core)
   input  logic             wr_access,  // one-cycle write strobe
   input  mio_pkg::packet_t wr_packet,  // packet to store
   output logic             full,       // no room left
   // read side (protocol engine)
   output logic             rd_access,  // head entry valid
   output mio_pkg::packet_t rd_packet,  // head entry
   input  logic             rd_wait     // engine not taking the head
);

   //#######################################################################
   // sizing
   //#######################################################################

   localparam int DEPTH = `MIO_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);   // address bits

   //#######################################################################
   // storage and pointers
   //#######################################################################

   mio_pkg::packet_t mem [DEPTH];          // packet storage

   // extra msb on each pointer tells full from empty
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;

   logic        empty;
   logic        do_write;
   logic        do_read;

   //#######################################################################
   // status
   //#######################################################################

   // same address, different wrap bit
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                  (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   assign empty = (wr_ptr == rd_ptr);

   // write while full is dropped here
   assign do_write = wr_access & ~full;

   // pop when head is valid and engine accepts
   assign do_read  = rd_access & ~rd_wait;

   //#######################################################################
   // pointer update
   //#######################################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_write)
            wr_ptr <= wr_ptr + 1'b1;          // wraps through the msb
         if (do_read)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // data array, no reset on payload
   always_ff @(posedge clk) begin
      if (do_write)
         mem[wr_ptr[AW-1:0]] <= wr_packet;
   end

   //#######################################################################
   // read port
   //#######################################################################

   // head visible right after the first write edge
   assign rd_access = ~empty;
   assign rd_packet = mem[rd_ptr[AW-1:0]];   // comb read of head

endmodule

//--- hdl/mtx_protocol.sv
// mtx_protocol: idle/busy engine, loads a packet and shifts out io words

`timescale 1ns/100ps

`include "mio_config.svh"

module mtx_protocol (
   input  logic              clk,          // core clock
   input  logic              nreset,       // async, active low
   // config
   input  mio_pkg::count_t   datasize,     // words per packet minus one
   // wide side (fifo)
   input  logic              fifo_access,  // head packet valid
   input  mio_pkg::packet_t  fifo_packet,  // head packet
   output logic              fifo_wait,    // hold the head
   // narrow side (io stage)
   output logic              io_access,    // word valid, high while busy
   output mio_pkg::io_word_t io_packet,    // current word
   input  logic              tx_wait       // synced pin back-pressure
);

   //#######################################################################
   // widths
   //#######################################################################

   localparam int PW = `MIO_PW;
   localparam int WW = 2*`MIO_IOW;          // one io word

   // two states only
   localparam logic ST_IDLE = 1'b0;
   localparam logic ST_BUSY = 1'b1;

   logic             state;
   logic             busy;
   logic             start_transfer;
   logic             transfer_done;
   mio_pkg::count_t  count;                // words left minus one
   mio_pkg::packet_t shift_data;           // packet being sent

   assign busy = (state == ST_BUSY);

   //#######################################################################
   // state machine
   //#######################################################################

   // back-pressure only checked before a packet starts
   assign start_transfer = fifo_access & ~tx_wait & ~busy;

   // last word on the pins this cycle
   assign transfer_done  = busy & (count == '0);

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         state <= ST_IDLE;
      else
         case (state)
            ST_IDLE: state <= start_transfer ? ST_BUSY : ST_IDLE;
            ST_BUSY: state <= transfer_done  ? ST_IDLE : ST_BUSY;
            default: state <= ST_IDLE;
         endcase
   end

   // down-counter, reloaded from datasize each idle cycle
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         count <= '0;
      else if (busy)
         count <= count - 1'b1;
      else
         count <= datasize;             // datasize+1 busy cycles
   end

   //#######################################################################
   // data shift register
   //#######################################################################

   // msb word first, zeros fill in from below
   always_ff @(posedge clk) begin
      if (busy)
         shift_data <= {shift_data[PW-WW-1:0], {WW{1'b0}}};
      else if (start_transfer)
         shift_data <= fifo_packet;
   end

   assign io_access = busy;
   assign io_packet = shift_data[PW-1:PW-WW];   // top slice

   //#######################################################################
   // wait back to fifo
   //#######################################################################

   // pop only on the start edge
   assign fifo_wait = busy | tx_wait;

endmodule

//--- hdl/mtx_io.sv
// mtx_io: output flops for the link word and strobe, pin wait synchronizer

`timescale 1ns/100ps

`include "mio_config.svh"

module mtx_io (
   input  logic              clk,          // core clock
   input  logic              nreset,       // async, active low
   // from protocol engine
   input  logic              core_access,  // word valid
   input  mio_pkg::io_word_t core_packet,  // word to send
   output logic              sync_wait,    // pin wait in clk domain
   // pins
   output logic              pin_access,   // registered strobe
   output mio_pkg::io_word_t pin_packet,   // registered word
   input  logic              pin_wait      // async from far end
);

   //#######################################################################
   // output retiming
   //#######################################################################

   localparam int NS = `MIO_SYNC_STAGES;

   logic [NS-1:0] sync_q;                  // synchronizer chain

   // strobe resets low so the pins stay quiet in reset
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         pin_access <= 1'b0;
      else
         pin_access <= core_access;
   end

   // word flop, payload only
   always_ff @(posedge clk) begin
      pin_packet <= core_packet;        // one cycle behind the engine
   end

   //#######################################################################
   // wait synchronizer
   //#######################################################################

   // pin_wait enters at bit 0, leaves at the top bit
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         sync_q <= '0;                  // no wait out of reset
      else
         sync_q <= {sync_q[NS-2:0], pin_wait};
   end

   // NS cycles of latency from the pin
   assign sync_wait = sync_q[NS-1];

endmodule

//--- hdl/mtx.sv
// mtx: transmit top level, fifo into protocol engine into io stage

`timescale 1ns/100ps

module mtx (
   input  logic              clk,        // core clock
   input  logic              nreset,     // async, active low
   // config, static while packets are in flight
   input  mio_pkg::count_t   datasize,   // words per packet minus one
   // core side
   input  logic              tx_access,  // one-cycle write strobe
   input  mio_pkg::packet_t  tx_packet,  // wide packet
   output logic              tx_wait,    // fifo full, no strobes
   // pin side
   output logic              io_access,  // high for each valid word
   output mio_pkg::io_word_t io_packet,  // word on the pins
   input  logic              io_wait     // async pin back-pressure
);

   //#######################################################################
   // internal links
   //#######################################################################

   logic              fifo_access;      // fifo not empty
   mio_pkg::packet_t  fifo_packet;      // fifo head
   logic              fifo_wait;        // engine holding the head
   logic              proto_access;     // engine busy
   mio_pkg::io_word_t proto_packet;     // engine word
   logic              sync_wait;        // synced io_wait

   // core packets buffered here, full is the core wait
   mtx_fifo u_fifo (
      .clk       (clk),
      .nreset    (nreset),
      .wr_access (tx_access),
      .wr_packet (tx_packet),
      .full      (tx_wait),
      .rd_access (fifo_access),
      .rd_packet (fifo_packet),
      .rd_wait   (fifo_wait)
   );

   // wide to narrow
   mtx_protocol u_protocol (
      .clk         (clk),
      .nreset      (nreset),
      .datasize    (datasize),
      .fifo_access (fifo_access),
      .fifo_packet (fifo_packet),
      .fifo_wait   (fifo_wait),
      .io_access   (proto_access),
      .io_packet   (proto_packet),
      .tx_wait     (sync_wait)
   );

   // pin flops and wait sync
   mtx_io u_io (
      .clk         (clk),
      .nreset      (nreset),
      .core_access (proto_access),
      .core_packet (proto_packet),
      .sync_wait   (sync_wait),
      .pin_access  (io_access),
      .pin_packet  (io_packet),
      .pin_wait    (io_wait)
   );

endmodule

//--- verification/mtx_checker.sv
// mtx_checker: concurrent assertions on the mtx ports, bound into mtx

`timescale 1ns/100ps

module mtx_checker (
   input logic              clk,
   input logic              nreset,
   input mio_pkg::count_t   datasize,
   input logic              tx_access,
   input logic              tx_wait,
   input logic              io_access,
   input mio_pkg::io_word_t io_packet
);

   int run_len;                              // words so far in this run

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         run_len <= 0;
      else if (io_access)
         run_len <= run_len + 1;
      else
         run_len <= 0;                       // cleared in the gap
   end

   // core holds off while the fifo is full
   no_write_when_full: assert property (
      @(posedge clk) disable iff (!nreset) tx_access |-> !tx_wait)
      else $error("tx_access strobed while tx_wait high");

   word_known: assert property (
      @(posedge clk) disable iff (!nreset) io_access |-> !$isunknown(io_packet))
      else $error("io_packet has X or Z while io_access high");

   quiet_in_reset: assert property (@(posedge clk) !nreset |-> !io_access)
      else $error("io_access high during reset");

   // run closes after datasize+1 words
   run_length: assert property (
      @(posedge clk) disable iff (!nreset)
      $fell(io_access) |-> (run_len == int'(datasize) + 1))
      else $error("io_access run of %0d words, datasize %0d", run_len, datasize);

endmodule

bind mtx mtx_checker u_checker (
   .clk       (clk),
   .nreset    (nreset),
   .datasize  (datasize),
   .tx_access (tx_access),
   .tx_wait   (tx_wait),
   .io_access (io_access),
   .io_packet (io_packet)
);

//--- verification/mtx_tb.sv
// mtx_tb: clock, reset, directed test tasks, reference model, timeout, summary

`timescale 1ns/100ps

`include "mio_config.svh"

module mtx_tb;

   localparam int PW           = `MIO_PW;
   localparam int WW           = 2*`MIO_IOW;    // one link word
   localparam int CLK_HALF     = 50;            // 100 ns period
   localparam int DRIVE_DLY    = 10;            // input skew after posedge
   localparam int RESET_CYCLES = 16;
   localparam int NUM_TESTS    = 6;
   localparam int NUM_RANDOM   = 40;
   // run budget: directed tests plus worst case per random packet, doubled
   localparam int DIRECTED_CYCLES   = 304;
   localparam int RANDOM_PKT_CYCLES = 42;
   localparam int TIMEOUT_CYCLES    =
      2 * (RESET_CYCLES + DIRECTED_CYCLES + NUM_RANDOM * RANDOM_PKT_CYCLES);

   logic              clk;
   logic              nreset;
   mio_pkg::count_t   datasize;
   logic              tx_access;
   mio_pkg::packet_t  tx_packet;
   logic              tx_wait;
   logic              io_access;
   mio_pkg::io_word_t io_packet;
   logic              io_wait;

   int    error_count;
   int    tests_run;
   int    cycles = 0;
   int    seed;
   string test_name;

   // reference model state
   mio_pkg::packet_t  exp_pkt_q[$];            // packets in flight, in order
   int                exp_size_q[$];           // datasize at send time
   mio_pkg::io_word_t run_words[$];            // words of the open run
   mio_pkg::io_word_t last_run[$];             // last finished run
   int                gap_q[$];                // low cycles before each run
   int                gap = 0;
   logic              in_run = 1'b0;

   mtx uut (
      .clk       (clk),
      .nreset    (nreset),
      .datasize  (datasize),
      .tx_access (tx_access),
      .tx_packet (tx_packet),
      .tx_wait   (tx_wait),
      .io_access (io_access),
      .io_packet (io_packet),
      .io_wait   (io_wait)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // hard stop on a hung run
   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: no finish after %0d cycles in test %s", cycles, test_name);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   //#######################################################################
   // helpers
   //#######################################################################

   task automatic value_error(string what, logic [127:0] expected, logic [127:0] actual);
      $display("** Error %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
      error_count++;
   endtask

   task automatic plain_error(string msg);
      $display("Error in %s: %s", test_name, msg);
      error_count++;
   endtask

   // word k of a packet, msb first, zeros from below
   function automatic mio_pkg::io_word_t slice_word(mio_pkg::packet_t p, int k);
      mio_pkg::packet_t s;
      s = p << (k*WW);
      return s[PW-1 -: WW];
   endfunction

   function automatic mio_pkg::packet_t random_packet();
      logic [127:0] r;
      r = {$random(seed), $random(seed), $random(seed), $random(seed)};
      return r[PW-1:0];
   endfunction

   task automatic step();
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   // one-cycle strobe, honours tx_wait, logs the packet in the model
   task automatic send_packet(mio_pkg::packet_t p);
      while (tx_wait)
         step();
      tx_access = 1'b1;
      tx_packet = p;
      exp_pkt_q.push_back(p);
      exp_size_q.push_back(int'(datasize));
      step();
      tx_access = 1'b0;
   endtask

   task automatic drain();
      while (exp_pkt_q.size() != 0)
         step();
      step();
   endtask

   task automatic finish_test(int errs_before);
      tests_run++;
      $display("test %-10s done, %0d errors", test_name, error_count - errs_before);
   endtask

   //#######################################################################
   // monitor, sampled mid-cycle
   //#######################################################################

   task automatic check_run();
      mio_pkg::packet_t pkt;
      int               exp_size;
      last_run  = run_words;
      run_words = {};
      if (exp_pkt_q.size() == 0) begin
         plain_error("io_access run with no packet outstanding");
      end else begin
         pkt      = exp_pkt_q.pop_front();
         exp_size = exp_size_q.pop_front();
         assert (last_run.size() == exp_size + 1)
            else value_error("run length", exp_size + 1, last_run.size());
         for (int k = 0; k < last_run.size() && k <= exp_size; k++) begin
            assert (last_run[k] === slice_word(pkt, k))
               else value_error("link word", slice_word(pkt, k), last_run[k]);
         end
      end
   endtask

   always @(negedge clk) begin
      if (nreset !== 1'b1) begin
         in_run = 1'b0;
         gap    = 0;
      end else if (io_access) begin
         if (!in_run)
            gap_q.push_back(gap);                // gap ahead of this run
         in_run = 1'b1;
         run_words.push_back(io_packet);
      end else begin
         if (in_run) begin
            check_run();                         // run just ended
            gap = 0;
         end
         in_run = 1'b0;
         gap++;
      end
   end

   //#######################################################################
   // tests
   //#######################################################################

   task automatic test_reset();
      int errs;
      errs      = error_count;
      test_name = "reset";
      nreset    = 1'b0;
      for (int i = 0; i < RESET_CYCLES; i++) begin
         step();
         assert (io_access === 1'b0 && tx_wait === 1'b0)
            else plain_error("io_access or tx_wait not low during reset");
      end
      nreset = 1'b1;
      repeat (4) begin
         step();
         assert (io_access === 1'b0 && tx_wait === 1'b0)
            else plain_error("io_access or tx_wait not low after reset");
      end
      finish_test(errs);
   endtask

   task automatic test_full_packet();
      int               errs;
      mio_pkg::packet_t pkt;
      errs      = error_count;
      test_name = "full_pkt";
      datasize  = 3;
      step();
      pkt = random_packet();
      send_packet(pkt);
      drain();
      assert (last_run.size() == 4) else value_error("words", 4, last_run.size());
      if (last_run.size() == 4) begin
         assert (last_run[0] === pkt[PW-1 -: WW])
            else value_error("word 0", pkt[PW-1 -: WW], last_run[0]);
         assert (last_run[1] === pkt[PW-1-WW -: WW])
            else value_error("word 1", pkt[PW-1-WW -: WW], last_run[1]);
         assert (last_run[2] === pkt[PW-1-2*WW -: WW])
            else value_error("word 2", pkt[PW-1-2*WW -: WW], last_run[2]);
         assert (last_run[3] === {pkt[PW-3*WW-1:0], {(4*WW-PW){1'b0}}})
            else value_error("word 3", {pkt[PW-3*WW-1:0], {(4*WW-PW){1'b0}}}, last_run[3]);
      end
      finish_test(errs);
   endtask

   task automatic test_short_sizes();
      int               errs;
      mio_pkg::packet_t pkt;
      errs      = error_count;
      test_name = "short";
      for (int sz = 0; sz < 2; sz++) begin
         datasize = mio_pkg::count_t'(sz);
         step();
         pkt = random_packet();
         send_packet(pkt);
         drain();
         assert (last_run.size() == sz + 1) else value_error("words", sz + 1, last_run.size());
         if (last_run.size() > 0)
            assert (last_run[0] === pkt[PW-1 -: WW])
               else value_error("word 0", pkt[PW-1 -: WW], last_run[0]);
         if (sz == 1 && last_run.size() > 1)
            assert (last_run[1] === pkt[PW-1-WW -: WW])
               else value_error("word 1", pkt[PW-1-WW -: WW], last_run[1]);
      end
      finish_test(errs);
   endtask

   task automatic test_burst();
      int   errs;
      logic saw_full;
      errs      = error_count;
      test_name = "burst";
      saw_full  = 1'b0;
      datasize  = 3;
      step();
      gap_q = {};
      for (int i = 0; i < 2*`MIO_FIFO_DEPTH; i++) begin
         if (tx_wait)
            saw_full = 1'b1;
         send_packet(random_packet());
      end
      drain();
      assert (saw_full) else plain_error("tx_wait never rose with the FIFO full");
      assert (gap_q.size() == 2*`MIO_FIFO_DEPTH)
         else value_error("runs", 2*`MIO_FIFO_DEPTH, gap_q.size());
      for (int i = 1; i < gap_q.size(); i++)
         assert (gap_q[i] == 1) else value_error("gap cycles", 1, gap_q[i]);
      finish_test(errs);
   endtask

   task automatic test_pin_wait();
      int errs;
      errs      = error_count;
      test_name = "pin_wait";
      datasize  = 3;
      io_wait   = 1'b1;
      repeat (`MIO_SYNC_STAGES + 2) step();      // let the wait reach the engine
      send_packet(random_packet());
      send_packet(random_packet());
      repeat (20) begin
         step();
         assert (io_access === 1'b0) else plain_error("io_access while io_wait held high");
      end
      assert (exp_pkt_q.size() == 2) else value_error("held packets", 2, exp_pkt_q.size());
      io_wait = 1'b0;
      drain();
      // wait rises mid-packet, packet still completes
      send_packet(random_packet());
      while (!io_access)
         step();
      io_wait = 1'b1;
      drain();
      io_wait = 1'b0;
      repeat (4) step();
      finish_test(errs);
   endtask

   task automatic test_random();
      int          errs;
      logic [31:0] r;
      errs      = error_count;
      test_name = "random";
      for (int i = 0; i < NUM_RANDOM; i++) begin
         if (exp_pkt_q.size() == 0 && !io_access) begin
            r        = $random(seed);
            datasize = mio_pkg::count_t'(r[1:0]);  // link idle here
         end
         r = $random(seed);
         if (r[2:0] == 3'd0) begin
            io_wait = 1'b1;                        // short pin wait pulse
            repeat (r[7:6] + 1) step();
            io_wait = 1'b0;
         end
         send_packet(random_packet());
         repeat (r[5:4]) step();
      end
      io_wait = 1'b0;
      drain();
      finish_test(errs);
   endtask

   //#######################################################################
   // main sequence
   //#######################################################################

   initial begin
      seed        = 32'hdb5c;
      nreset      = 1'b1;
      datasize    = '0;
      tx_access   = 1'b0;
      tx_packet   = '0;
      io_wait     = 1'b0;
      error_count = 0;
      tests_run   = 0;
      test_name   = "init";
      #5;
      test_reset();
      test_full_packet();
      test_short_sizes();
      test_burst();
      test_pin_wait();
      test_random();
      $display("tests run %0d of %0d, errors %0d", tests_run, NUM_TESTS, error_count);
      if (error_count == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- files.f
+incdir+hdl
hdl/mio_pkg.sv
hdl/mtx_fifo.sv
hdl/mtx_protocol.sv
hdl/mtx_io.sv
hdl/mtx.sv
verification/mtx_checker.sv
verification/mtx_tb.sv

//--- Makefile
# Verilator flow for the mtx transmit path: lint, sim, clean

VERILATOR  ?= verilator
TOP        ?= mtx_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= NO ERRORS
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
SIM_ARGS   ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := hdl/mio_config.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# pass only if the log holds the pass line
sim: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
